/* hdl/cache_dma_pkg.sv */
`default_nettype none

package cache_dma_pkg;

  // byte address seen by the cache DMA port
  localparam int dma_addr_width = 28;

  // data beats per block transfer
  localparam int burst_len = 4;

  // width of one data beat
  localparam int dma_data_width = 32;

  // one mask bit per beat
  localparam int dma_mask_width = 4;

  // counter width for walking the beats of a burst
  localparam int beat_width = $clog2(burst_len);

  // request issued by the cache for a writeback or a fill
  typedef struct packed {
    logic                      write_not_read;
    logic [dma_addr_width-1:0] addr;
    logic [dma_mask_width-1:0] mask;
  } dma_pkt_s;

endpackage

`default_nettype wire

/* hdl/wormhole_pkg.sv */
`default_nettype none

package wormhole_pkg;

  localparam int flit_width = 32;
  localparam int cord_width = 5;
  localparam int cid_width  = 2;
  localparam int len_width  = 4;

  typedef logic [flit_width-1:0] flit_t;

  typedef enum logic [1:0] {
    wh_read,
    wh_write_full,
    wh_write_masked,
    wh_read_resp
  } wh_opcode_e;

  // destination fields sit in the low bits, len counts flits after the header
  typedef struct packed {
    logic [flit_width-2-cid_width-cord_width-len_width-cid_width-cord_width-1:0] unused;
    wh_opcode_e            opcode;
    logic [cid_width-1:0]  src_cid;
    logic [cord_width-1:0] src_cord;
    logic [len_width-1:0]  len;
    logic [cid_width-1:0]  cid;
    logic [cord_width-1:0] cord;
  } wh_header_s;

  // fixed node addresses on the link
  localparam logic [cord_width-1:0] cache_cord = 5'd1;
  localparam logic [cid_width-1:0]  cache_cid  = 2'd0;
  localparam logic [cord_width-1:0] mem_cord   = 5'd2;
  localparam logic [cid_width-1:0]  mem_cid    = 2'd1;

  // memory node storage
  localparam int mem_words = 64;
  localparam int mem_index_width = $clog2(mem_words);

endpackage

`default_nettype wire

/* hdl/two_slot_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module two_slot_fifo #(
  parameter type payload_t = logic
) (
  input  wire        clk_i,
  input  wire        reset_i,

  input  wire        v_i,
  input  wire payload_t data_i,
  output logic       ready_o,

  output logic       v_o,
  output payload_t   data_o,
  input  wire        yumi_i
);

  payload_t slot_mem [2];
  logic [1:0] full_r;
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic       enq;
  logic       deq;

  // a slot can be filled while the other one drains, so no bubbles
  assign ready_o = ~full_r[wr_ptr_r];
  assign v_o     = full_r[rd_ptr_r];
  assign data_o  = slot_mem[rd_ptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_r   <= 2'b00;
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
    end else begin
      // enq and deq never target the same slot in one cycle
      if (enq) begin
        full_r[wr_ptr_r] <= 1'b1;
        wr_ptr_r         <= ~wr_ptr_r;
      end
      if (deq) begin
        full_r[rd_ptr_r] <= 1'b0;
        rd_ptr_r         <= ~rd_ptr_r;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      slot_mem[wr_ptr_r] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/dma_to_wormhole.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_to_wormhole
  import cache_dma_pkg::*;
  import wormhole_pkg::*;
(
  input  wire                       clk_i,
  input  wire                       reset_i,

  input  wire dma_pkt_s             dma_pkt_i,
  input  wire                       dma_pkt_v_i,
  output logic                      dma_pkt_yumi_o,

  input  wire [dma_data_width-1:0]  dma_data_i,
  input  wire                       dma_data_v_i,
  output logic                      dma_data_yumi_o,

  output logic [dma_data_width-1:0] dma_data_o,
  output logic                      dma_data_v_o,
  input  wire                       dma_data_ready_i,

  output logic                      req_v_o,
  output flit_t                     req_data_o,
  input  wire                       req_ready_i,

  input  wire                       rsp_v_i,
  input  wire flit_t                rsp_data_i,
  output logic                      rsp_ready_o
);

  if (flit_width < dma_addr_width) begin : g_addr_fits
    $error("flit width %0d cannot carry a %0d bit address", flit_width, dma_addr_width);
  end
  if ((burst_len + 2) >= (1 << len_width)) begin : g_len_fits
    $error("len width %0d cannot hold burst length %0d plus 2", len_width, burst_len);
  end

  // packet queue, keeps a fill waiting behind a writeback
  logic     pkt_ready;
  logic     pkt_v;
  logic     pkt_yumi;
  dma_pkt_s pkt;

  two_slot_fifo #(
    .payload_t(dma_pkt_s)
  ) pkt_queue (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (dma_pkt_v_i),
    .data_i (dma_pkt_i),
    .ready_o(pkt_ready),
    .v_o    (pkt_v),
    .data_o (pkt),
    .yumi_i (pkt_yumi)
  );

  assign dma_pkt_yumi_o = pkt_ready & dma_pkt_v_i;

  // return buffer on the response direction
  logic  ret_v;
  logic  ret_ready;
  logic  ret_yumi;
  flit_t ret_data;

  two_slot_fifo #(
    .payload_t(flit_t)
  ) return_buffer (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (rsp_v_i),
    .data_i (rsp_data_i),
    .ready_o(rsp_ready_o),
    .v_o    (ret_v),
    .data_o (ret_data),
    .yumi_i (ret_yumi)
  );

  assign ret_yumi = ret_ready & ret_v;

  typedef enum logic [2:0] {
    send_reset,
    send_header,
    send_addr,
    send_mask,
    send_data
  } send_state_e;

  typedef enum logic [1:0] {
    recv_reset,
    recv_header,
    recv_data
  } recv_state_e;

  send_state_e send_state_r, send_state_n;
  recv_state_e recv_state_r, recv_state_n;

  logic [beat_width-1:0] send_cnt_r;
  logic [beat_width-1:0] recv_cnt_r;
  logic send_up, send_last;
  logic recv_up, recv_last;
  logic mask_all_one;
  wh_header_s header;

  assign mask_all_one = &pkt.mask;

  always_comb begin
    header          = '0;
    header.src_cid  = cache_cid;
    header.src_cord = cache_cord;
    header.cid      = mem_cid;
    header.cord     = mem_cord;
    if (!pkt.write_not_read) begin
      header.opcode = wh_read;
      header.len    = len_width'(1);
    end else if (mask_all_one) begin
      header.opcode = wh_write_full;
      header.len    = len_width'(burst_len + 1);
    end else begin
      header.opcode = wh_write_masked;
      header.len    = len_width'(burst_len + 2);
    end
  end

  // send FSM
  always_comb begin
    send_state_n    = send_state_r;
    req_v_o         = 1'b0;
    req_data_o      = dma_data_i;
    dma_data_yumi_o = 1'b0;
    pkt_yumi        = 1'b0;
    send_up         = 1'b0;
    send_last       = (send_cnt_r == beat_width'(burst_len - 1));
    case (send_state_r)
      send_reset: send_state_n = send_header;
      send_header: begin
        req_data_o = header;
        req_v_o    = pkt_v;
        if (pkt_v && req_ready_i) send_state_n = send_addr;
      end
      send_addr: begin
        req_data_o = flit_t'(pkt.addr);
        req_v_o    = pkt_v;
        if (pkt_v && req_ready_i) begin
          // a masked write keeps its packet until the mask flit is out
          pkt_yumi = ~pkt.write_not_read | mask_all_one;
          if (!pkt.write_not_read) send_state_n = send_header;
          else send_state_n = mask_all_one ? send_data : send_mask;
        end
      end
      send_mask: begin
        req_data_o = flit_t'(pkt.mask);
        req_v_o    = pkt_v;
        if (pkt_v && req_ready_i) begin
          pkt_yumi     = 1'b1;
          send_state_n = send_data;
        end
      end
      send_data: begin
        req_v_o         = dma_data_v_i;
        dma_data_yumi_o = dma_data_v_i & req_ready_i;
        send_up         = dma_data_yumi_o;
        if (dma_data_yumi_o && send_last) send_state_n = send_header;
      end
      default: send_state_n = send_header;
    endcase
  end

  // receive FSM, the return header is dropped
  always_comb begin
    recv_state_n = recv_state_r;
    ret_ready    = 1'b0;
    dma_data_v_o = 1'b0;
    dma_data_o   = ret_data;
    recv_up      = 1'b0;
    recv_last    = (recv_cnt_r == beat_width'(burst_len - 1));
    case (recv_state_r)
      recv_reset: recv_state_n = recv_header;
      recv_header: begin
        ret_ready = 1'b1;
        if (ret_v) recv_state_n = recv_data;
      end
      recv_data: begin
        ret_ready    = dma_data_ready_i;
        dma_data_v_o = ret_v;
        recv_up      = ret_yumi;
        if (ret_yumi && recv_last) recv_state_n = recv_header;
      end
      default: recv_state_n = recv_header;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r <= send_reset;
      recv_state_r <= recv_reset;
      send_cnt_r   <= '0;
      recv_cnt_r   <= '0;
    end else begin
      send_state_r <= send_state_n;
      recv_state_r <= recv_state_n;
      // beat counters wrap back to zero after the last beat
      if (send_up) send_cnt_r <= send_last ? '0 : send_cnt_r + 1'b1;
      if (recv_up) recv_cnt_r <= recv_last ? '0 : recv_cnt_r + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/wormhole_mem_endpoint.sv */
`timescale 1ns/1ps
`default_nettype none

module wormhole_mem_endpoint
  import cache_dma_pkg::*;
  import wormhole_pkg::*;
(
  input  wire        clk_i,
  input  wire        reset_i,

  input  wire        req_v_i,
  input  wire flit_t req_data_i,
  output logic       req_ready_o,

  output logic       rsp_v_o,
  output flit_t      rsp_data_o,
  input  wire        rsp_ready_i
);

  typedef enum logic [2:0] {
    ep_clear,
    ep_header,
    ep_addr,
    ep_mask,
    ep_write,
    ep_resp_header,
    ep_resp_data
  } ep_state_e;

  ep_state_e state_r, state_n;

  logic [flit_width-1:0]      mem [mem_words];
  logic [mem_index_width-1:0] clear_cnt_r;
  logic [mem_index_width-1:0] base_r;
  logic [mem_index_width-1:0] word_index;
  logic [beat_width-1:0]      beat_r;
  logic [dma_mask_width-1:0]  mask_r;
  logic [cord_width-1:0]      src_cord_r;
  logic [cid_width-1:0]       src_cid_r;
  wh_opcode_e                 opcode_r;
  wh_header_s                 req_header;
  wh_header_s                 resp_header;
  logic beat_up;
  logic beat_last;
  logic wr_en;

  assign req_header = req_data_i;
  assign word_index = base_r + mem_index_width'(beat_r);
  assign beat_last  = (beat_r == beat_width'(burst_len - 1));
  assign wr_en      = (state_r == ep_write) & req_v_i & mask_r[beat_r];

  always_comb begin
    resp_header          = '0;
    resp_header.opcode   = wh_read_resp;
    resp_header.src_cid  = mem_cid;
    resp_header.src_cord = mem_cord;
    resp_header.len      = len_width'(burst_len);
    resp_header.cid      = src_cid_r;
    resp_header.cord     = src_cord_r;
  end

  always_comb begin
    state_n     = state_r;
    req_ready_o = 1'b0;
    rsp_v_o     = 1'b0;
    rsp_data_o  = mem[word_index];
    beat_up     = 1'b0;
    case (state_r)
      // requests wait until every word has been zeroed
      ep_clear: if (clear_cnt_r == mem_index_width'(mem_words - 1)) state_n = ep_header;
      ep_header: begin
        req_ready_o = 1'b1;
        if (req_v_i) state_n = ep_addr;
      end
      ep_addr: begin
        req_ready_o = 1'b1;
        if (req_v_i) begin
          case (opcode_r)
            wh_write_full:   state_n = ep_write;
            wh_write_masked: state_n = ep_mask;
            default:         state_n = ep_resp_header;
          endcase
        end
      end
      ep_mask: begin
        req_ready_o = 1'b1;
        if (req_v_i) state_n = ep_write;
      end
      ep_write: begin
        req_ready_o = 1'b1;
        beat_up     = req_v_i;
        if (req_v_i && beat_last) state_n = ep_header;
      end
      ep_resp_header: begin
        rsp_v_o    = 1'b1;
        rsp_data_o = resp_header;
        if (rsp_ready_i) state_n = ep_resp_data;
      end
      ep_resp_data: begin
        rsp_v_o = 1'b1;
        beat_up = rsp_ready_i;
        if (rsp_ready_i && beat_last) state_n = ep_header;
      end
      default: state_n = ep_header;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= ep_clear;
      clear_cnt_r <= '0;
      beat_r      <= '0;
    end else begin
      state_r <= state_n;
      if (state_r == ep_clear) clear_cnt_r <= clear_cnt_r + 1'b1;
      if (beat_up) beat_r <= beat_last ? '0 : beat_r + 1'b1;
    end
  end

  // request fields captured as they arrive
  always_ff @(posedge clk_i) begin
    if (state_r == ep_header && req_v_i) begin
      opcode_r   <= req_header.opcode;
      src_cord_r <= req_header.src_cord;
      src_cid_r  <= req_header.src_cid;
    end
    if (state_r == ep_addr && req_v_i) begin
      // byte address to word index
      base_r <= req_data_i[mem_index_width+1:2];
      mask_r <= '1;
    end
    if (state_r == ep_mask && req_v_i) mask_r <= req_data_i[dma_mask_width-1:0];
  end

  always_ff @(posedge clk_i) begin
    if (state_r == ep_clear) mem[clear_cnt_r] <= '0;
    else if (wr_en) mem[word_index] <= req_data_i;
  end

endmodule

`default_nettype wire

/* hdl/dma_wormhole_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_wormhole_top
  import cache_dma_pkg::*;
  import wormhole_pkg::*;
(
  input  wire                       clk_i,
  input  wire                       reset_i,

  input  wire dma_pkt_s             dma_pkt_i,
  input  wire                       dma_pkt_v_i,
  output logic                      dma_pkt_yumi_o,

  input  wire [dma_data_width-1:0]  dma_data_i,
  input  wire                       dma_data_v_i,
  output logic                      dma_data_yumi_o,

  output logic [dma_data_width-1:0] dma_data_o,
  output logic                      dma_data_v_o,
  input  wire                       dma_data_ready_i
);

  // request and response directions of the link
  logic  req_v;
  flit_t req_data;
  logic  req_ready;
  logic  rsp_v;
  flit_t rsp_data;
  logic  rsp_ready;

  dma_to_wormhole bridge (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .dma_pkt_i       (dma_pkt_i),
    .dma_pkt_v_i     (dma_pkt_v_i),
    .dma_pkt_yumi_o  (dma_pkt_yumi_o),
    .dma_data_i      (dma_data_i),
    .dma_data_v_i    (dma_data_v_i),
    .dma_data_yumi_o (dma_data_yumi_o),
    .dma_data_o      (dma_data_o),
    .dma_data_v_o    (dma_data_v_o),
    .dma_data_ready_i(dma_data_ready_i),
    .req_v_o         (req_v),
    .req_data_o      (req_data),
    .req_ready_i     (req_ready),
    .rsp_v_i         (rsp_v),
    .rsp_data_i      (rsp_data),
    .rsp_ready_o     (rsp_ready)
  );

  wormhole_mem_endpoint mem_node (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_v_i    (req_v),
    .req_data_i (req_data),
    .req_ready_o(req_ready),
    .rsp_v_o    (rsp_v),
    .rsp_data_o (rsp_data),
    .rsp_ready_i(rsp_ready)
  );

endmodule

`default_nettype wire

/* sim/dma_wormhole_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_wormhole_assertions
  import wormhole_pkg::*;
(
  input wire        clk_i,
  input wire        reset_i,
  input wire        req_v_i,
  input wire flit_t req_data_i,
  input wire        req_ready_i,
  input wire        data_v_i,
  input wire        data_yumi_i,
  input wire        ret_v_i
);

  // number of failed assertions, the testbench reads it at the end of the run
  int fail_count = 0;

  // a flit offered to a stalled link stays put
  req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_v_i && !req_ready_i) |=> (req_v_i && $stable(req_data_i)))
  else begin
    fail_count++;
    $error("request flit or valid changed while the link was stalled");
  end

  // write data is only consumed when it is offered
  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    data_yumi_i |-> data_v_i)
  else begin
    fail_count++;
    $error("write data consumed without valid");
  end

  // both FSMs sit in their reset state one cycle after reset
  quiet_after_reset: assert property (@(posedge clk_i)
    reset_i |=> (!req_v_i && !ret_v_i))
  else begin
    fail_count++;
    $error("outbound valid high in the cycle after reset");
  end

endmodule

bind dma_to_wormhole dma_wormhole_assertions link_checks (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .req_v_i    (req_v_o),
  .req_data_i (req_data_o),
  .req_ready_i(req_ready_i),
  .data_v_i   (dma_data_v_i),
  .data_yumi_i(dma_data_yumi_o),
  .ret_v_i    (dma_data_v_o)
);

`default_nettype wire

/* sim/tb_dma_wormhole.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dma_wormhole
  import cache_dma_pkg::*;
  import wormhole_pkg::*;
();

  localparam int num_ops = 13;
  localparam int wait_limit = 2000;
  localparam logic [31:0] random_seed = 32'h31ed_732b;

  // one row of the operation table
  typedef struct packed {
    logic                      write_not_read;
    logic [dma_addr_width-1:0] addr;
    logic [dma_mask_width-1:0] mask;
    logic                      data_stall;
    logic                      ready_stall;
  } op_s;

  logic                      clk;
  logic                      reset;
  dma_pkt_s                  pkt;
  logic                      pkt_v;
  logic                      pkt_yumi;
  logic [dma_data_width-1:0] wr_data;
  logic                      wr_data_v;
  logic                      wr_data_yumi;
  logic [dma_data_width-1:0] rd_data;
  logic                      rd_data_v;
  logic                      rd_data_ready;

  op_s                       ops [num_ops];
  string                     op_name [num_ops];
  logic [flit_width-1:0]     model_mem [mem_words];

  dma_wormhole_top DUT (
    .clk_i           (clk),
    .reset_i         (reset),
    .dma_pkt_i       (pkt),
    .dma_pkt_v_i     (pkt_v),
    .dma_pkt_yumi_o  (pkt_yumi),
    .dma_data_i      (wr_data),
    .dma_data_v_i    (wr_data_v),
    .dma_data_yumi_o (wr_data_yumi),
    .dma_data_o      (rd_data),
    .dma_data_v_o    (rd_data_v),
    .dma_data_ready_i(rd_data_ready)
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("FAILED %s expected %h actual %h", test_name, expected, actual));
    end
  endtask

  // word touched by a beat, the node holds mem_words words of 4 bytes
  function automatic int word_index(input logic [dma_addr_width-1:0] addr, input int beat);
    return ((addr >> 2) + beat) % mem_words;
  endfunction

  task automatic set_op(input int i, input string name, input logic wnr,
                        input logic [dma_addr_width-1:0] addr,
                        input logic [dma_mask_width-1:0] mask,
                        input logic data_stall, input logic ready_stall);
    op_name[i] = name;
    ops[i] = '{wnr, addr, mask, data_stall, ready_stall};
  endtask

  task automatic load_ops();
    set_op(0, "read_unwritten", 1'b0, 28'h040, 4'hf, 1'b0, 1'b0);
    set_op(1, "full_write", 1'b1, 28'h040, 4'hf, 1'b0, 1'b0);
    set_op(2, "full_readback", 1'b0, 28'h040, 4'hf, 1'b0, 1'b0);
    set_op(3, "masked_write", 1'b1, 28'h040, 4'b0101, 1'b0, 1'b0);
    set_op(4, "masked_readback", 1'b0, 28'h040, 4'hf, 1'b0, 1'b0);
    set_op(5, "fill_prepare", 1'b1, 28'h0c0, 4'hf, 1'b1, 1'b0);
    set_op(6, "writeback", 1'b1, 28'h080, 4'b1010, 1'b0, 1'b0);
    set_op(7, "fill_after_writeback", 1'b0, 28'h0c0, 4'hf, 1'b0, 1'b0);
    set_op(8, "gapped_write", 1'b1, 28'h000, 4'hf, 1'b1, 1'b0);
    set_op(9, "stalled_read", 1'b0, 28'h000, 4'hf, 1'b0, 1'b1);
    set_op(10, "gapped_masked_write", 1'b1, 28'h0f0, 4'b0110, 1'b1, 1'b0);
    set_op(11, "stalled_masked_read", 1'b0, 28'h0f0, 4'hf, 1'b1, 1'b1);
    set_op(12, "stalled_writeback_read", 1'b0, 28'h080, 4'hf, 1'b0, 1'b1);
  endtask

  task automatic watch_idle_outputs(input string test_name, input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      check_value(test_name, 32'd0, {29'd0, rd_data_v, wr_data_yumi, pkt_yumi});
    end
  endtask

  // packets go out as fast as the queue takes them
  task automatic issue_packets();
    dma_pkt_s next_pkt;
    int       wait_cycles;
    for (int i = 0; i < num_ops; i++) begin
      next_pkt.write_not_read = ops[i].write_not_read;
      next_pkt.addr           = ops[i].addr;
      next_pkt.mask           = ops[i].mask;
      pkt         <= next_pkt;
      pkt_v       <= 1'b1;
      wait_cycles = 0;
      @(posedge clk);
      while (!pkt_yumi) begin
        wait_cycles++;
        if (wait_cycles > wait_limit) begin
          abort_run($sformatf("packet for %s was never taken", op_name[i]));
        end
        @(posedge clk);
      end
    end
    pkt_v <= 1'b0;
  endtask

  task automatic drive_write_data(input int op);
    logic [dma_data_width-1:0] beats [burst_len];
    int   beat;
    int   gap;
    int   wait_cycles;
    logic presenting;
    for (int b = 0; b < burst_len; b++) begin
      beats[b] = $urandom;
    end
    beat        = 0;
    gap         = 0;
    wait_cycles = 0;
    presenting  = 1'b1;
    wr_data   <= beats[0];
    wr_data_v <= 1'b1;
    while (beat < burst_len) begin
      @(posedge clk);
      // no read is outstanding while write data flows
      check_value({op_name[op], " no return data"}, 32'd0, {31'd0, rd_data_v});
      if (presenting && wr_data_yumi) begin
        if (ops[op].mask[beat]) begin
          model_mem[word_index(ops[op].addr, beat)] = beats[beat];
        end
        beat++;
        wait_cycles = 0;
        presenting  = 1'b0;
        gap = ops[op].data_stall ? int'($urandom % 3) : 0;
      end else begin
        wait_cycles++;
        if (wait_cycles > wait_limit) begin
          abort_run($sformatf("write data for %s was not consumed", op_name[op]));
        end
        if (!presenting && gap > 0) gap--;
      end
      if (!presenting && gap == 0 && beat < burst_len) begin
        wr_data    <= beats[beat];
        presenting = 1'b1;
      end
      wr_data_v <= presenting;
    end
  endtask

  task automatic collect_read(input int op);
    int beat;
    int wait_cycles;
    beat        = 0;
    wait_cycles = 0;
    rd_data_ready <= ops[op].ready_stall ? ($urandom % 4 != 0) : 1'b1;
    while (beat < burst_len) begin
      @(posedge clk);
      if (rd_data_v && rd_data_ready) begin
        check_value($sformatf("%s beat %0d", op_name[op], beat),
                    model_mem[word_index(ops[op].addr, beat)], rd_data);
        beat++;
        wait_cycles = 0;
      end else begin
        wait_cycles++;
        if (wait_cycles > wait_limit) begin
          abort_run($sformatf("read %s did not return all beats", op_name[op]));
        end
      end
      rd_data_ready <= ops[op].ready_stall ? ($urandom % 4 != 0) : 1'b1;
    end
    rd_data_ready <= 1'b0;
  endtask

  task automatic process_data();
    for (int i = 0; i < num_ops; i++) begin
      if (ops[i].write_not_read) drive_write_data(i);
      else collect_read(i);
    end
  endtask

  initial begin
    void'($urandom(random_seed));
    clk           = 1'b0;
    reset         = 1'b1;
    pkt           = '0;
    pkt_v         = 1'b0;
    wr_data       = '0;
    wr_data_v     = 1'b0;
    rd_data_ready = 1'b0;
    // memory node starts out cleared
    for (int w = 0; w < mem_words; w++) begin
      model_mem[w] = '0;
    end
    load_ops();
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    watch_idle_outputs("idle_after_reset", 16);
    fork
      issue_packets();
      process_data();
    join
    watch_idle_outputs("idle_after_run", 8);
    if (DUT.bridge.link_checks.fail_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run("link protocol assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

/* compile.f */
hdl/cache_dma_pkg.sv
hdl/wormhole_pkg.sv
hdl/two_slot_fifo.sv
hdl/dma_to_wormhole.sv
hdl/wormhole_mem_endpoint.sv
hdl/dma_wormhole_top.sv
sim/dma_wormhole_assertions.sv
sim/tb_dma_wormhole.sv
